/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= alu_tb
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/alu_asserts.sv */
`timescale 1ns/1ps

module alu_asserts import alu_pkg::*, wb_pkg::*; (
  input logic     clk,
  input logic     rst_n_i,
  input wb_req_t  wb_req_i,
  input wb_rsp_t  wb_rsp_i,
  input alu_cmd_t cmd_i,
  input logic     done_i
);

  // number of failed assertions
  int unsigned fail_cnt = 0;

  // ack is a one-cycle pulse
  ack_single: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_rsp_i.ack |=> !wb_rsp_i.ack)
    else begin
      fail_cnt++;
      $error("ack held for more than one cycle");
    end

  // no ack outside a bus cycle
  ack_in_cycle: assert property (@(posedge clk) disable iff (!rst_n_i)
    wb_rsp_i.ack |-> (wb_req_i.cyc && wb_req_i.stb))
    else begin
      fail_cnt++;
      $error("ack without cyc and stb");
    end

  // decode and result registers put done two cycles behind the launch
  done_latency: assert property (@(posedge clk) disable iff (!rst_n_i)
    $past(cmd_i.valid, 2) |-> done_i)
    else begin
      fail_cnt++;
      $error("done not set two cycles after launch");
    end

  // done never rises early or without a launch
  done_only_after_cmd: assert property (@(posedge clk) disable iff (!rst_n_i)
    $rose(done_i) |-> $past(cmd_i.valid, 2))
    else begin
      fail_cnt++;
      $error("done rose without a launch two cycles before");
    end

endmodule

bind alu_top alu_asserts alu_asserts_i (
  .clk      (clk),
  .rst_n_i  (rst_n_i),
  .wb_req_i (wb_req_i),
  .wb_rsp_i (wb_rsp_o),
  .cmd_i    (cmd),
  .done_i   (done)
);

/* bench/alu_checker.sv */
`timescale 1ns/1ps

module alu_checker import alu_pkg::*, wb_pkg::*; #(
  parameter bit USE_LI  = 1'b0,
  parameter bit USE_INT = 1'b1,
  parameter bit USE_SFT = 1'b1,
  parameter bit USE_CMP = 1'b1
)(
  input  logic        clk,
  input  logic        rst_n_i,
  input  wb_req_t     wb_req_i,
  input  wb_rsp_t     wb_rsp_i,
  output int unsigned test_cnt_o,
  output int unsigned chk_cnt_o,
  output int unsigned err_cnt_o
);

  int unsigned edge_cnt = 0;
  int unsigned cmd_edge = 0;
  int unsigned err_at_cmd = 0;
  int unsigned test_cnt = 0;
  int unsigned chk_cnt = 0;
  int unsigned err_cnt = 0;
  logic        cmd_seen = 1'b0;
  logic        fresh;
  logic [3:0]  op_m = 4'd0;
  logic [31:0] r0_m = '0;
  logic [31:0] r1_m = '0;
  logic [31:0] pc_m = '0;
  logic [31:0] exp_new = '0;
  logic [31:0] exp_old = '0;
  logic        ill_new = 1'b0;
  logic        ill_old = 1'b0;

  // expected {illegal, data}, disabled groups give the logic op of the same sub code
  function automatic logic [32:0] alu_model(input logic [3:0] op, input logic [31:0] r0,
                                            input logic [31:0] r1, input logic [31:0] pc);
    logic [31:0] li;
    logic [31:0] fill;
    logic [31:0] sra;
    logic        lts;
    logic [32:0] res;
    li   = {r0[19:0], 12'd0};
    fill = r1[31] ? ~(32'hffff_ffff >> r0[4:0]) : 32'd0;
    sra  = (r1 >> r0[4:0]) | fill;
    // signed less-than, opposite signs decided by r1's sign
    lts  = (r1[31] ^ r0[31]) ? r1[31] : (r1 < r0);
    case (op)
      4'd0:  res = {1'b0, ~(r0 | r1)};
      4'd1:  res = {1'b0, r0 & r1};
      4'd2:  res = {1'b0, r0 | r1};
      4'd3:  res = {1'b0, r0 ^ r1};
      4'd4:  res = {1'b0, USE_INT ? r1 + r0 : (USE_LI ? li : ~(r0 | r1))};
      4'd5:  res = {1'b0, USE_INT ? r1 - r0 : (USE_LI ? pc + 32'd4 : r0 | r1)};
      4'd6:  res = {1'b0, USE_INT ? r1 + r0 : (USE_LI ? li : r0 & r1)};
      4'd7:  res = {1'b0, USE_INT ? r1 - r0 : (USE_LI ? pc + li : r0 ^ r1)};
      4'd8:  res = {1'b0, USE_INT ? r1 - r0 : (USE_LI ? pc + 32'd4 : r0 | r1)};
      4'd9:  res = {1'b0, USE_SFT ? r1 << r0[4:0] : ~(r0 | r1)};
      4'd10: res = {1'b0, USE_SFT ? r1 >> r0[4:0] : r0 & r1};
      4'd11: res = {1'b0, USE_SFT ? sra : r0 | r1};
      4'd12: res = {1'b0, USE_CMP ? {31'd0, lts} : ~(r0 | r1)};
      4'd13: res = {1'b0, USE_CMP ? {31'd0, r1 < r0} : r0 & r1};
      // unused codes, nor of zeros
      default: res = {1'b1, 32'hffff_ffff};
    endcase
    return res;
  endfunction

  task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
    chk_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %0t ns: %s read 0x%h, expected 0x%h", $time, what, got, exp);
    end
  endtask

  always @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      edge_cnt <= 0;
    end else begin
      edge_cnt <= edge_cnt + 1;
    end
  end

  // mid-cycle sampling, request is held through the ack cycle
  always @(negedge clk) begin
    if (rst_n_i && wb_rsp_i.ack) begin
      if (wb_req_i.we) begin
        case (wb_req_i.adr)
          REG_R0: r0_m = wb_req_i.dat;
          REG_R1: r1_m = wb_req_i.dat;
          REG_PC: pc_m = wb_req_i.dat;
          REG_CMD: begin
            exp_old = exp_new;
            ill_old = ill_new;
            op_m    = wb_req_i.dat[3:0];
            {ill_new, exp_new} = alu_model(op_m, r0_m, r1_m, pc_m);
            cmd_edge   = edge_cnt;
            cmd_seen   = 1'b1;
            err_at_cmd = err_cnt;
          end
          default: ;
        endcase
      end else begin
        // result register loads two edges after the cmd ack, read sees it one edge later
        fresh = cmd_seen && (edge_cnt - cmd_edge >= 3);
        if (wb_req_i.adr == REG_STATUS) begin
          compare("status", wb_rsp_i.dat, {30'd0, fresh ? ill_new : ill_old, fresh});
        end else if (wb_req_i.adr == REG_RESULT) begin
          compare("result", wb_rsp_i.dat, fresh ? exp_new : exp_old);
          test_cnt++;
          $display("test %0d: op %0d r0 0x%h r1 0x%h result 0x%h %s", test_cnt, op_m,
                   r0_m, r1_m, wb_rsp_i.dat, (err_cnt == err_at_cmd) ? "pass" : "FAIL");
          err_at_cmd = err_cnt;
        end
      end
    end
  end

  assign test_cnt_o = test_cnt;
  assign chk_cnt_o  = chk_cnt;
  assign err_cnt_o  = err_cnt;

endmodule

/* bench/alu_tb.sv */
`timescale 1ns/1ps

module alu_tb import alu_pkg::*, wb_pkg::*; ();

  localparam bit USE_LI  = 1'b0;
  localparam bit USE_INT = 1'b1;
  localparam bit USE_SFT = 1'b1;
  localparam bit USE_CMP = 1'b1;

  logic        clk;
  logic        rst_n_i;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  int unsigned cyc_cnt = 0;
  int unsigned timeouts = 0;
  int unsigned test_cnt;
  int unsigned chk_cnt;
  int unsigned err_cnt;

  // 100 ns period
  always #50 clk = ~clk;

  always @(posedge clk) begin
    cyc_cnt <= cyc_cnt + 1;
  end

  alu_top #(
    .USE_LI  (USE_LI),
    .USE_INT (USE_INT),
    .USE_SFT (USE_SFT),
    .USE_CMP (USE_CMP)
  ) alu_top_i (
    .clk      (clk),
    .rst_n_i  (rst_n_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

  alu_checker #(
    .USE_LI  (USE_LI),
    .USE_INT (USE_INT),
    .USE_SFT (USE_SFT),
    .USE_CMP (USE_CMP)
  ) alu_checker_i (
    .clk        (clk),
    .rst_n_i    (rst_n_i),
    .wb_req_i   (wb_req),
    .wb_rsp_i   (wb_rsp),
    .test_cnt_o (test_cnt),
    .chk_cnt_o  (chk_cnt),
    .err_cnt_o  (err_cnt)
  );

  // one classic cycle started 1 ns after a rising edge
  // request stays up through the ack cycle and drops after the next edge
  task automatic bus_access(input logic we, input logic [2:0] adr, input logic [31:0] dat,
                            output logic [31:0] rdat);
    int unsigned waited;
    waited      = 0;
    rdat        = '0;
    wb_req.cyc  = 1'b1;
    wb_req.stb  = 1'b1;
    wb_req.we   = we;
    wb_req.adr  = adr;
    wb_req.dat  = dat;
    @(posedge clk);
    #1;
    while (!wb_rsp.ack && waited < 20) begin
      waited++;
      @(posedge clk);
      #1;
    end
    if (wb_rsp.ack) begin
      rdat = wb_rsp.dat;
    end else begin
      timeouts++;
      $display("timeout: register %0d never acknowledged the access", adr);
    end
    @(posedge clk);
    #1;
    wb_req.cyc = 1'b0;
    wb_req.stb = 1'b0;
  endtask

  task automatic write_reg(input logic [2:0] adr, input logic [31:0] dat);
    logic [31:0] unused;
    bus_access(1'b1, adr, dat, unused);
  endtask

  task automatic read_reg(input logic [2:0] adr, output logic [31:0] dat);
    bus_access(1'b0, adr, 32'd0, dat);
  endtask

  // load operands and launch then poll status and fetch the result
  task automatic run_cmd(input logic [3:0] op, input logic [31:0] r0, input logic [31:0] r1,
                         input logic [31:0] pc);
    logic [31:0] sts;
    logic [31:0] res;
    int unsigned start;
    write_reg(REG_R0, r0);
    write_reg(REG_R1, r1);
    write_reg(REG_PC, pc);
    write_reg(REG_CMD, {28'd0, op});
    start = cyc_cnt;
    sts   = '0;
    while (!sts[STS_DONE] && (cyc_cnt - start) < 20) begin
      read_reg(REG_STATUS, sts);
    end
    if (!sts[STS_DONE]) begin
      timeouts++;
      $display("timeout: done never set for opcode %0d", op);
    end
    read_reg(REG_RESULT, res);
  endtask

  initial begin
    logic [31:0] rd;
    logic [31:0] a;
    logic [31:0] b;
    int unsigned seed_ret;
    int unsigned assert_fails;
    int          i;
    seed_ret = $urandom(32'h3d5f_7b15);
    clk      = 1'b0;
    rst_n_i  = 1'b0;
    wb_req   = '0;
    repeat (3) @(posedge clk);
    #1;
    rst_n_i = 1'b1;
    // reset values
    read_reg(REG_STATUS, rd);
    read_reg(REG_RESULT, rd);
    // logic group on random operands
    for (i = 0; i < 8; i++) begin
      a = $urandom;
      b = $urandom;
      run_cmd(4'(i % 4), a, b, 32'd0);
    end
    // wrap around then the lui family folded onto add and sub
    run_cmd(OP_ADD, 32'h0000_0001, 32'hffff_ffff, 32'd0);
    run_cmd(OP_SUB, 32'h0000_0001, 32'h0000_0000, 32'd0);
    for (i = 4; i < 9; i++) begin
      a = $urandom;
      b = $urandom;
      run_cmd(4'(i), a, b, $urandom);
    end
    // shifts by 0, 31 and a random amount on negative r1
    for (i = 9; i < 12; i++) begin
      run_cmd(4'(i), 32'd0, 32'h8765_4321, 32'd0);
      run_cmd(4'(i), 32'd31, 32'h8765_4321, 32'd0);
      a = $urandom;
      run_cmd(4'(i), a, 32'hf000_00f0, 32'd0);
    end
    // signed and unsigned compare with the edge pair both ways
    for (i = 12; i < 14; i++) begin
      run_cmd(4'(i), 32'h7fff_ffff, 32'h8000_0000, 32'd0);
      run_cmd(4'(i), 32'h8000_0000, 32'h7fff_ffff, 32'd0);
      run_cmd(4'(i), 32'h1234_5678, 32'h1234_5678, 32'd0);
    end
    // unused opcodes then a legal one that clears the flag
    run_cmd(4'd14, 32'h1111_1111, 32'h2222_2222, 32'd0);
    run_cmd(4'd15, 32'h3333_3333, 32'h4444_4444, 32'd0);
    run_cmd(OP_XOR, 32'h0f0f_0f0f, 32'hffff_0000, 32'd0);
    @(posedge clk);
    #1;
    assert_fails = alu_top_i.alu_asserts_i.fail_cnt;
    $display("%0d tests, %0d checks, %0d errors, %0d timeouts, %0d assertion failures",
             test_cnt, chk_cnt, err_cnt, timeouts, assert_fails);
    if (err_cnt == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* hdl/alu_decode.sv */
`timescale 1ns/1ps

module alu_decode import alu_pkg::*; (
  input  logic      clk,
  input  logic      rst_n_i,
  input  alu_cmd_t  cmd_i,
  output alu_ctrl_t ctrl_o
);

  alu_ctrl_t ctrl_d;
  alu_ctrl_t ctrl_q;

  always_comb begin
    ctrl_d.valid   = cmd_i.valid;
    ctrl_d.grp     = GRP_LOGIC;
    ctrl_d.sub     = SOP_NOR;
    ctrl_d.illegal = 1'b0;
    ctrl_d.r0      = cmd_i.r0;
    ctrl_d.r1      = cmd_i.r1;
    ctrl_d.pc      = cmd_i.pc;
    case (cmd_i.op)
      // logic group
      OP_NOR: ctrl_d.sub = SOP_NOR;
      OP_AND: ctrl_d.sub = SOP_AND;
      OP_OR:  ctrl_d.sub = SOP_OR;
      OP_XOR: ctrl_d.sub = SOP_XOR;
      // integer group
      OP_ADD: begin
        ctrl_d.grp = GRP_INT;
        ctrl_d.sub = SOP_ADD;
      end
      OP_SUB: begin
        ctrl_d.grp = GRP_INT;
        ctrl_d.sub = SOP_SUB;
      end
      // load immediate shares the integer slot
      OP_LUI: begin
        ctrl_d.grp = GRP_INT;
        ctrl_d.sub = SOP_LUI;
      end
      OP_PCADDU12I: begin
        ctrl_d.grp = GRP_INT;
        ctrl_d.sub = SOP_PCADDU12I;
      end
      OP_PCPLUS4: begin
        ctrl_d.grp = GRP_INT;
        ctrl_d.sub = SOP_PCPLUS4;
      end
      // shifts
      OP_SLL: begin
        ctrl_d.grp = GRP_SFT;
        ctrl_d.sub = SOP_SLL;
      end
      OP_SRL: begin
        ctrl_d.grp = GRP_SFT;
        ctrl_d.sub = SOP_SRL;
      end
      OP_SRA: begin
        ctrl_d.grp = GRP_SFT;
        ctrl_d.sub = SOP_SRA;
      end
      // compares
      OP_SLT: begin
        ctrl_d.grp = GRP_CMP;
        ctrl_d.sub = SOP_SLT;
      end
      OP_SLTU: begin
        ctrl_d.grp = GRP_CMP;
        ctrl_d.sub = SOP_SLTU;
      end
      // unused codes, nor of zeros gives all ones
      default: begin
        ctrl_d.illegal = 1'b1;
        ctrl_d.r0      = '0;
        ctrl_d.r1      = '0;
        ctrl_d.pc      = '0;
      end
    endcase
  end

  // decode pipeline register
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else begin
      ctrl_q <= ctrl_d;
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

/* hdl/alu_execute.sv */
`timescale 1ns/1ps

module alu_execute import alu_pkg::*; #(
  parameter bit USE_LI  = 1'b0,
  parameter bit USE_INT = 1'b1,
  parameter bit USE_SFT = 1'b1,
  parameter bit USE_CMP = 1'b1
)(
  input  alu_ctrl_t ctrl_i,
  output alu_res_t  res_o
);

  logic [31:0] r0;
  logic [31:0] r1;
  logic [31:0] pc;
  alu_sub_e    sub;
  logic [31:0] g0_result;
  logic [31:0] g1_result;
  logic [31:0] g2_result;
  logic [31:0] g3_result;
  logic [31:0] res_w;
  logic        ext;
  logic [32:0] r0_x;
  logic [32:0] r1_x;
  logic [32:0] sub_r;

  assign r0  = ctrl_i.r0;
  assign r1  = ctrl_i.r1;
  assign pc  = ctrl_i.pc;
  assign sub = ctrl_i.sub;

  // logic group, always built
  always_comb begin
    case (sub)
      SOP_NOR: g0_result = ~(r1 | r0);
      SOP_AND: g0_result = r1 & r0;
      SOP_OR:  g0_result = r1 | r0;
      default: g0_result = r1 ^ r0;
    endcase
  end

  // shared subtractor
  // extra top bit is inverted sign for signed compare, zero for unsigned
  assign ext   = ~sub[0];
  assign r1_x  = {~r1[31] & ext, r1};
  assign r0_x  = {~r0[31] & ext, r0};
  assign sub_r = r1_x - r0_x;

  // integer unit wins over load immediate
  if (USE_INT) begin : g_int
    always_comb begin
      if (sub[1]) begin
        g1_result = sub_r[31:0];
      end else begin
        g1_result = r1 + r0;
      end
    end
  end else if (USE_LI) begin : g_li
    always_comb begin
      case (sub)
        SOP_PCPLUS4:   g1_result = pc + 32'd4;
        SOP_PCADDU12I: g1_result = {r0[19:0], 12'd0} + pc;
        // lui, also the code 00 leftover
        default:       g1_result = {r0[19:0], 12'd0};
      endcase
    end
  end else begin : g_no_int
    assign g1_result = '0;
  end

  // shifter, amount from r0 low bits
  if (USE_SFT) begin : g_sft
    always_comb begin
      case (sub)
        SOP_SRL: g2_result = r1 >> r0[4:0];
        SOP_SRA: g2_result = $unsigned($signed(r1) >>> r0[4:0]);
        default: g2_result = r1 << r0[4:0];
      endcase
    end
  end else begin : g_no_sft
    assign g2_result = '0;
  end

  // borrow out of the 33-bit subtract is the less-than flag
  if (USE_CMP) begin : g_cmp
    assign g3_result = {31'd0, sub_r[32]};
  end else begin : g_no_cmp
    assign g3_result = '0;
  end

  // group mux, groups not built fall back to logic
  always_comb begin
    case (ctrl_i.grp)
      GRP_INT: res_w = (USE_LI || USE_INT) ? g1_result : g0_result;
      GRP_SFT: res_w = USE_SFT ? g2_result : g0_result;
      GRP_CMP: res_w = USE_CMP ? g3_result : g0_result;
      default: res_w = g0_result;
    endcase
  end

  assign res_o.valid   = ctrl_i.valid;
  assign res_o.illegal = ctrl_i.illegal;
  assign res_o.data    = res_w;

endmodule

/* hdl/alu_pkg.sv */
package alu_pkg;

  // opcode field of the cmd register, codes 14 and 15 left unused
  typedef enum logic [3:0] {
    OP_NOR       = 4'd0,
    OP_AND       = 4'd1,
    OP_OR        = 4'd2,
    OP_XOR       = 4'd3,
    OP_ADD       = 4'd4,
    OP_SUB       = 4'd5,
    OP_LUI       = 4'd6,
    OP_PCADDU12I = 4'd7,
    OP_PCPLUS4   = 4'd8,
    OP_SLL       = 4'd9,
    OP_SRL       = 4'd10,
    OP_SRA       = 4'd11,
    OP_SLT       = 4'd12,
    OP_SLTU      = 4'd13
  } alu_op_e;

  // datapath group, logic group is the fallback
  typedef enum logic [1:0] {
    GRP_LOGIC = 2'b00,
    GRP_INT   = 2'b01,
    GRP_SFT   = 2'b10,
    GRP_CMP   = 2'b11
  } alu_grp_e;

  // sub-operation inside a group, code points shared between groups
  typedef logic [1:0] alu_sub_e;

  localparam alu_sub_e SOP_NOR       = 2'b00;
  localparam alu_sub_e SOP_AND       = 2'b01;
  localparam alu_sub_e SOP_OR        = 2'b10;
  localparam alu_sub_e SOP_XOR       = 2'b11;
  localparam alu_sub_e SOP_ADD       = 2'b00;
  localparam alu_sub_e SOP_SUB       = 2'b10;
  localparam alu_sub_e SOP_LUI       = 2'b01;
  localparam alu_sub_e SOP_PCPLUS4   = 2'b10;
  localparam alu_sub_e SOP_PCADDU12I = 2'b11;
  localparam alu_sub_e SOP_SLL       = 2'b00;
  localparam alu_sub_e SOP_SRL       = 2'b01;
  localparam alu_sub_e SOP_SRA       = 2'b10;
  // bit 0 clear means sign extension in the subtractor
  localparam alu_sub_e SOP_SLT       = 2'b00;
  localparam alu_sub_e SOP_SLTU      = 2'b01;

  // command launched by the register block
  typedef struct packed {
    logic        valid;
    alu_op_e     op;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] pc;
  } alu_cmd_t;

  // decoded command
  typedef struct packed {
    logic        valid;
    alu_grp_e    grp;
    alu_sub_e    sub;
    logic        illegal;
    logic [31:0] r0;
    logic [31:0] r1;
    logic [31:0] pc;
  } alu_ctrl_t;

  // execute output
  typedef struct packed {
    logic        valid;
    logic        illegal;
    logic [31:0] data;
  } alu_res_t;

endpackage

/* hdl/alu_result.sv */
`timescale 1ns/1ps

module alu_result import alu_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  alu_res_t    res_i,
  input  logic        clr_i,
  output logic        done_o,
  output logic        illegal_o,
  output logic [31:0] result_o
);

  logic        done_q;
  logic        illegal_q;
  logic [31:0] data_q;

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_q    <= 1'b0;
      illegal_q <= 1'b0;
      data_q    <= '0;
    end else begin
      // launch of a newer command beats a finishing one
      if (clr_i) begin
        done_q <= 1'b0;
      end else if (res_i.valid) begin
        done_q <= 1'b1;
      end
      // result and flag held until the next command finishes
      if (res_i.valid) begin
        illegal_q <= res_i.illegal;
        data_q    <= res_i.data;
      end
    end
  end

  // done drops in the launch cycle already
  assign done_o    = done_q & ~clr_i;
  assign illegal_o = illegal_q;
  assign result_o  = data_q;

endmodule

/* hdl/alu_top.sv */
`timescale 1ns/1ps

module alu_top import alu_pkg::*, wb_pkg::*; #(
  parameter bit USE_LI  = 1'b0,
  parameter bit USE_INT = 1'b1,
  parameter bit USE_SFT = 1'b1,
  parameter bit USE_CMP = 1'b1
)(
  input  logic    clk,
  input  logic    rst_n_i,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  alu_cmd_t    cmd;
  alu_ctrl_t   ctrl;
  alu_res_t    res;
  logic        done;
  logic        illegal;
  logic [31:0] result;

  // bus slave and command launch
  alu_wb_regs alu_wb_regs_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .wb_req_i  (wb_req_i),
    .wb_rsp_o  (wb_rsp_o),
    .cmd_o     (cmd),
    .done_i    (done),
    .illegal_i (illegal),
    .result_i  (result)
  );

  // decode stage
  alu_decode alu_decode_i (
    .clk     (clk),
    .rst_n_i (rst_n_i),
    .cmd_i   (cmd),
    .ctrl_o  (ctrl)
  );

  // execute, combinational
  alu_execute #(
    .USE_LI  (USE_LI),
    .USE_INT (USE_INT),
    .USE_SFT (USE_SFT),
    .USE_CMP (USE_CMP)
  ) alu_execute_i (
    .ctrl_i (ctrl),
    .res_o  (res)
  );

  // result stage, cleared by each launch
  alu_result alu_result_i (
    .clk       (clk),
    .rst_n_i   (rst_n_i),
    .res_i     (res),
    .clr_i     (cmd.valid),
    .done_o    (done),
    .illegal_o (illegal),
    .result_o  (result)
  );

endmodule

/* hdl/alu_wb_regs.sv */
`timescale 1ns/1ps

module alu_wb_regs import alu_pkg::*, wb_pkg::*; (
  input  logic        clk,
  input  logic        rst_n_i,
  input  wb_req_t     wb_req_i,
  output wb_rsp_t     wb_rsp_o,
  output alu_cmd_t    cmd_o,
  input  logic        done_i,
  input  logic        illegal_i,
  input  logic [31:0] result_i
);

  logic        ack_q;
  logic        req_w;
  logic        wr_w;
  logic        launch_q;
  alu_op_e     op_q;
  logic [31:0] r0_q;
  logic [31:0] r1_q;
  logic [31:0] pc_q;
  logic [31:0] rdat_d;
  logic [31:0] rdat_q;

  // new access, ignored during its own ack cycle
  assign req_w = wb_req_i.cyc & wb_req_i.stb & ~ack_q;
  assign wr_w  = req_w & wb_req_i.we;

  // read mux, write-only registers read as zero
  always_comb begin
    rdat_d = '0;
    case (wb_req_i.adr)
      REG_STATUS: begin
        rdat_d[STS_DONE]    = done_i;
        rdat_d[STS_ILLEGAL] = illegal_i;
      end
      REG_RESULT: rdat_d = result_i;
      default: rdat_d = '0;
    endcase
  end

  // ack, read data and writes all land on the same edge
  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q    <= 1'b0;
      launch_q <= 1'b0;
      rdat_q   <= '0;
      op_q     <= OP_NOR;
      r0_q     <= '0;
      r1_q     <= '0;
      pc_q     <= '0;
    end else begin
      ack_q    <= req_w;
      // one-cycle pulse per cmd write
      launch_q <= wr_w && (wb_req_i.adr == REG_CMD);
      // data bus stays zero outside the ack cycle
      rdat_q   <= (req_w && !wb_req_i.we) ? rdat_d : '0;
      if (wr_w) begin
        case (wb_req_i.adr)
          REG_R0:  r0_q <= wb_req_i.dat;
          REG_R1:  r1_q <= wb_req_i.dat;
          REG_PC:  pc_q <= wb_req_i.dat;
          // codes 14 and 15 kept as written, decode flags them
          REG_CMD: op_q <= alu_op_e'(wb_req_i.dat[3:0]);
          default: ;
        endcase
      end
    end
  end

  assign wb_rsp_o.ack = ack_q;
  assign wb_rsp_o.dat = rdat_q;

  // operands are stable while the pulse is out
  assign cmd_o.valid = launch_q;
  assign cmd_o.op    = op_q;
  assign cmd_o.r0    = r0_q;
  assign cmd_o.r1    = r1_q;
  assign cmd_o.pc    = pc_q;

endmodule

/* hdl/wb_pkg.sv */
package wb_pkg;

  // classic wishbone request, word addressed
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [2:0]  adr;
    logic [31:0] dat;
  } wb_req_t;

  // slave response
  typedef struct packed {
    logic        ack;
    logic [31:0] dat;
  } wb_rsp_t;

  // register map, word addresses
  localparam logic [2:0] REG_R0     = 3'd0;
  localparam logic [2:0] REG_R1     = 3'd1;
  localparam logic [2:0] REG_PC     = 3'd2;
  localparam logic [2:0] REG_CMD    = 3'd3;
  localparam logic [2:0] REG_STATUS = 3'd4;
  localparam logic [2:0] REG_RESULT = 3'd5;

  // status bits
  localparam int STS_DONE    = 0;
  localparam int STS_ILLEGAL = 1;

endpackage

/* project.f */
hdl/alu_pkg.sv
hdl/wb_pkg.sv
hdl/alu_wb_regs.sv
hdl/alu_decode.sv
hdl/alu_execute.sv
hdl/alu_result.sv
hdl/alu_top.sv
bench/alu_asserts.sv
bench/alu_checker.sv
bench/alu_tb.sv
